//--- source/ctrlport_pkg.sv
// ControlPort bus definitions

`default_nettype none

package ctrlport_pkg;

  // ----------------------------
  // Field widths
  // ----------------------------

  localparam int ctrlport_addr_w = 20;
  localparam int ctrlport_data_w = 32;
  // One enable per data byte
  localparam int ctrlport_be_w   = ctrlport_data_w / 8;
  localparam int ctrlport_sts_w  = 2;

  // Response status codes
  typedef enum logic [ctrlport_sts_w-1:0] {
    sts_okay   = 2'd0,
    sts_cmderr = 2'd1,
    sts_tsterr = 2'd2,
    sts_slverr = 2'd3
  } ctrlport_sts_t;

  // ----------------------------
  // Request and response
  // ----------------------------

  // Request, 58 bits; wr is a one-cycle strobe
  typedef struct packed {
    logic                       wr;
    logic                       rd;
    logic [ctrlport_addr_w-1:0] addr;
    logic [ctrlport_data_w-1:0] data;
    logic [ctrlport_be_w-1:0]   byte_en;
  } ctrlport_req_t;

  // Response, 35 bits; ack is a one-cycle pulse with status
  typedef struct packed {
    logic                       ack;
    ctrlport_sts_t              status;
    logic [ctrlport_data_w-1:0] data;
  } ctrlport_resp_t;

endpackage

`default_nettype wire

//--- source/led_pkg.sv
// Board LED payloads

`default_nettype none

package led_pkg;

  // ----------------------------
  // LED payload words
  // ----------------------------

  // QSFP cage LEDs, four lanes per field
  // Last member is the low nibble
  typedef struct packed {
    logic [3:0] qsfp1_active;
    logic [3:0] qsfp1_link;
    logic [3:0] qsfp0_active;
    logic [3:0] qsfp0_link;
  } qsfp_led_t;

  // Front-panel LEDs, two bits each
  typedef struct packed {
    logic [1:0] link;
    logic [1:0] activity;
    logic [1:0] ref_lock;
    logic [1:0] gps_lock;
  } panel_led_t;

  // ----------------------------
  // CPLD register map
  // ----------------------------

  localparam logic [ctrlport_pkg::ctrlport_addr_w-1:0] qsfp_led_reg_addr  = 20'h00040;
  localparam logic [ctrlport_pkg::ctrlport_addr_w-1:0] panel_led_reg_addr = 20'h00044;

  // Settling counter width, 256 cycles per delay
  localparam int settle_count_w = 8;

endpackage

`default_nettype wire

//--- source/synchronizer.sv
// Two-stage bit synchronizer

`timescale 1ns/1ps
`default_nettype none

module synchronizer #(
  parameter int width = 1
) (
  input  wire logic             ctrlport_clk,
  input  wire logic             ctrlport_rst,
  input  wire logic [width-1:0] async_in,
  output logic      [width-1:0] sync_out
);

  // First stage may go metastable
  (* async_reg = "true" *) logic [width-1:0] sync_meta;
  // Second stage settles it out
  (* async_reg = "true" *) logic [width-1:0] sync_stage;

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      sync_meta  <= '0;
      sync_stage <= '0;
    end else begin
      sync_meta  <= async_in;
      sync_stage <= sync_meta;
    end
  end

  // Two cycles from input change to output
  assign sync_out = sync_stage;

endmodule

`default_nettype wire

//--- source/led_status_forwarder.sv
// LED status write engine

`timescale 1ns/1ps
`default_nettype none

module led_status_forwarder #(
  parameter type payload_t = logic [7:0],
  parameter logic [ctrlport_pkg::ctrlport_addr_w-1:0] reg_addr = '0
) (
  input  wire logic                        ctrlport_clk,
  input  wire logic                        ctrlport_rst,
  input  wire payload_t                    led_in,
  output ctrlport_pkg::ctrlport_req_t      req,
  input  wire ctrlport_pkg::ctrlport_resp_t resp
);

  import ctrlport_pkg::*;
  import led_pkg::*;

  // Payload size sets the byte enables
  localparam int payload_w     = $bits(payload_t);
  localparam int payload_bytes = (payload_w + 7) / 8;
  localparam logic [ctrlport_be_w-1:0] byte_en_val =
    ctrlport_be_w'((1 << payload_bytes) - 1);

  // Last value of the settling count
  localparam logic [settle_count_w-1:0] settle_max = '1;

  typedef enum logic [1:0] {
    st_settle,
    st_write,
    st_wait_ack,
    st_idle
  } state_t;

  // ----------------------------
  // Clock-domain crossing
  // ----------------------------

  payload_t led_sync;

  synchronizer #(
    .width (payload_w)
  ) led_sync_i (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .async_in     (led_in),
    .sync_out     (led_sync)
  );

  // ----------------------------
  // Write state machine
  // ----------------------------

  state_t                    state;
  logic [settle_count_w-1:0] settle_count;
  // Value tracked while settling, frozen once it goes out
  payload_t                  led_prev;

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      state        <= st_settle;
      settle_count <= '0;
      led_prev     <= '0;
    end else begin
      case (state)
        st_settle: begin
          // Counter wraps to zero on exit, ready for next settle
          settle_count <= settle_count + settle_count_w'(1);
          led_prev     <= led_sync;
          if (settle_count == settle_max) begin
            state <= st_write;
          end
        end
        st_write: begin
          // Strobe is decoded from this state
          state <= st_wait_ack;
        end
        st_wait_ack: begin
          // Bad status means try again after another delay
          if (resp.ack) begin
            state <= (resp.status == sts_okay) ? st_idle : st_settle;
          end
        end
        st_idle: begin
          // Changes made while waiting are caught here too
          if (led_sync != led_prev) begin
            state <= st_settle;
          end
        end
        default: begin
          state <= st_settle;
        end
      endcase
    end
  end

  // ----------------------------
  // Request fields
  // ----------------------------

  always_comb begin
    req.wr      = (state == st_write);
    // Reads are never issued
    req.rd      = 1'b0;
    req.addr    = reg_addr;
    // Payload zero-extended to the bus
    req.data    = ctrlport_data_w'(led_prev);
    req.byte_en = byte_en_val;
  end

endmodule

`default_nettype wire

//--- source/ctrlport_combiner.sv
// Two-to-one ControlPort merge

`timescale 1ns/1ps
`default_nettype none

module ctrlport_combiner (
  input  wire logic                         ctrlport_clk,
  input  wire logic                         ctrlport_rst,
  input  wire ctrlport_pkg::ctrlport_req_t  s0_req,
  output ctrlport_pkg::ctrlport_resp_t      s0_resp,
  input  wire ctrlport_pkg::ctrlport_req_t  s1_req,
  output ctrlport_pkg::ctrlport_resp_t      s1_resp,
  output ctrlport_pkg::ctrlport_req_t       m_req,
  input  wire ctrlport_pkg::ctrlport_resp_t m_resp
);

  import ctrlport_pkg::*;

  // Index 0 is s0, index 1 is s1
  ctrlport_req_t in_req   [2];
  ctrlport_req_t pend_req [2];
  logic [1:0]    pend_valid;
  logic [1:0]    want;

  // One write in flight at most
  logic          busy;
  logic          owner;
  logic          bus_free;
  logic          grant_valid;
  logic          grant_side;
  ctrlport_req_t sel_req;

  // Registered master request
  logic          m_wr;
  ctrlport_req_t m_hold;

  assign in_req[0] = s0_req;
  assign in_req[1] = s1_req;

  // ----------------------------
  // Arbitration
  // ----------------------------

  always_comb begin
    want[0]     = pend_valid[0] | in_req[0].wr;
    want[1]     = pend_valid[1] | in_req[1].wr;
    // Ack frees the bus for the next edge
    bus_free    = !busy || m_resp.ack;
    grant_valid = bus_free && (want != 2'b00);
    // Fixed priority, s0 wins a tie
    grant_side  = !want[0];
    // A held slot goes before a fresh strobe
    sel_req     = pend_valid[grant_side] ? pend_req[grant_side] : in_req[grant_side];
  end

  // Control state
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      pend_valid <= '0;
      busy       <= 1'b0;
      owner      <= 1'b0;
      m_wr       <= 1'b0;
    end else begin
      m_wr <= 1'b0;
      if (m_resp.ack) begin
        busy <= 1'b0;
      end
      // Every strobe lands in its slot unless granted below
      for (int i = 0; i < 2; i++) begin
        if (in_req[i].wr) begin
          pend_valid[i] <= 1'b1;
        end
      end
      if (grant_valid) begin
        m_wr                   <= 1'b1;
        busy                   <= 1'b1;
        owner                  <= grant_side;
        pend_valid[grant_side] <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge ctrlport_clk) begin
    for (int i = 0; i < 2; i++) begin
      if (in_req[i].wr) begin
        pend_req[i] <= in_req[i];
      end
    end
    if (grant_valid) begin
      m_hold <= sel_req;
    end
  end

  // ----------------------------
  // Outputs
  // ----------------------------

  always_comb begin
    m_req.wr      = m_wr;
    m_req.rd      = 1'b0;
    m_req.addr    = m_hold.addr;
    m_req.data    = m_hold.data;
    m_req.byte_en = m_hold.byte_en;
  end

  // Ack and status reach the owner only
  assign s0_resp = owner ? '0 : m_resp;
  assign s1_resp = owner ? m_resp : '0;

endmodule

`default_nettype wire

//--- source/led_link_top.sv
// LED status link to CPLD

`timescale 1ns/1ps
`default_nettype none

module led_link_top (
  input  wire logic                         ctrlport_clk,
  input  wire logic                         ctrlport_rst,
  input  wire led_pkg::qsfp_led_t           qsfp_leds,
  input  wire led_pkg::panel_led_t          panel_leds,
  output ctrlport_pkg::ctrlport_req_t       m_req,
  input  wire ctrlport_pkg::ctrlport_resp_t m_resp
);

  import ctrlport_pkg::*;
  import led_pkg::*;

  // Forwarder side of the combiner
  ctrlport_req_t  qsfp_req;
  ctrlport_resp_t qsfp_resp;
  ctrlport_req_t  panel_req;
  ctrlport_resp_t panel_resp;

  // ----------------------------
  // Status forwarders
  // ----------------------------

  // QSFP lanes, high priority port
  led_status_forwarder #(
    .payload_t (qsfp_led_t),
    .reg_addr  (qsfp_led_reg_addr)
  ) qsfp_fwd (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .led_in       (qsfp_leds),
    .req          (qsfp_req),
    .resp         (qsfp_resp)
  );

  // Front panel
  led_status_forwarder #(
    .payload_t (panel_led_t),
    .reg_addr  (panel_led_reg_addr)
  ) panel_fwd (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .led_in       (panel_leds),
    .req          (panel_req),
    .resp         (panel_resp)
  );

  // ----------------------------
  // Bus merge
  // ----------------------------

  ctrlport_combiner combiner_i (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .s0_req       (qsfp_req),
    .s0_resp      (qsfp_resp),
    .s1_req       (panel_req),
    .s1_resp      (panel_resp),
    .m_req        (m_req),
    .m_resp       (m_resp)
  );

endmodule

`default_nettype wire

//--- bench/led_link_tb.sv
// LED link testbench

`timescale 1ns/1ps
`default_nettype none

module led_link_tb;

  import ctrlport_pkg::*;
  import led_pkg::*;

  // ----------------------------
  // Timing constants
  // ----------------------------

  localparam int  clk_period    = 10;
  localparam int  settle_cycles = 1 << settle_count_w;
  localparam int  max_ack       = 20;
  localparam int  margin        = 200;
  localparam int  n_tests       = 5;
  // Long enough to catch a stray retry after the last ack
  localparam int  quiet_cycles  = 400;
  localparam int  long_window   = 1000;
  localparam int  watchdog_cycles = n_tests * (settle_cycles + max_ack + margin) * 4;
  localparam time min_gap       = time'(settle_cycles * clk_period);

  typedef struct packed {
    logic [ctrlport_data_w-1:0] data;
    logic [ctrlport_be_w-1:0]   byte_en;
  } exp_write_t;

  // One write as seen by the CPLD model
  typedef struct {
    logic [ctrlport_addr_w-1:0] addr;
    logic [ctrlport_data_w-1:0] data;
    logic [ctrlport_be_w-1:0]   byte_en;
    time                        t;
  } write_rec_t;

  logic           ctrlport_clk = 1'b0;
  logic           ctrlport_rst;
  qsfp_led_t      qsfp_leds;
  panel_led_t     panel_leds;
  ctrlport_req_t  m_req;
  ctrlport_resp_t m_resp;

  // Last LED words driven for the compare process
  logic [15:0] qsfp_val;
  logic [7:0]  panel_val;

  write_rec_t                 wr_q[$];
  logic [ctrlport_addr_w-1:0] seen_addr[$];
  time                        seen_time[$];
  time                        ack_time[$];
  int   inject_errs = 0;
  int   errors      = 0;
  int   writes_checked = 0;
  int   tests_run   = 0;
  int   test_err_start;
  logic outstanding = 1'b0;

  led_link_top uut (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .qsfp_leds    (qsfp_leds),
    .panel_leds   (panel_leds),
    .m_req        (m_req),
    .m_resp       (m_resp)
  );

  always #(clk_period / 2) ctrlport_clk = ~ctrlport_clk;

  // Expected data and byte enables for a register and its LED word
  function automatic exp_write_t expected_write(input logic [ctrlport_addr_w-1:0] addr,
                                                input logic [ctrlport_data_w-1:0] led_value);
    exp_write_t e;
    if (addr == qsfp_led_reg_addr) begin
      e.data    = {16'h0, led_value[15:0]};
      e.byte_en = 4'b0011;
    end else begin
      e.data    = {24'h0, led_value[7:0]};
      e.byte_en = 4'b0001;
    end
    return e;
  endfunction

  // ----------------------------
  // CPLD responder model
  // ----------------------------

  always begin : cpld_model
    int         delay;
    write_rec_t rec;
    @(posedge ctrlport_clk);
    if (!ctrlport_rst && m_req.wr) begin
      rec.addr    = m_req.addr;
      rec.data    = m_req.data;
      rec.byte_en = m_req.byte_en;
      rec.t       = $time;
      wr_q.push_back(rec);
      delay = $urandom_range(1, max_ack);
      repeat (delay) @(negedge ctrlport_clk);
      // Error status only when the test asks for it
      m_resp.ack    = 1'b1;
      m_resp.status = (inject_errs > 0) ? sts_slverr : sts_okay;
      if (inject_errs > 0) begin
        inject_errs--;
      end
      ack_time.push_back($time);
      @(negedge ctrlport_clk);
      m_resp.ack    = 1'b0;
      m_resp.status = sts_okay;
    end
  end

  // No reads and one write in flight at most
  always @(posedge ctrlport_clk) begin
    if (!ctrlport_rst) begin
      assert (!m_req.rd) else begin
        $display("[FAIL] m_req.rd: expected 0x0, got 0x%0h", m_req.rd);
        errors++;
      end
      if (m_req.wr) begin
        assert (!outstanding) else begin
          $display("Second write issued before the first was acknowledged");
          errors++;
        end
        outstanding = 1'b1;
      end else if (m_resp.ack) begin
        outstanding = 1'b0;
      end
    end
  end

  // ----------------------------
  // Compare process
  // ----------------------------

  always @(negedge ctrlport_clk) begin : compare
    write_rec_t got;
    exp_write_t exp;
    while (wr_q.size() > 0) begin
      got = wr_q.pop_front();
      assert (got.addr == qsfp_led_reg_addr || got.addr == panel_led_reg_addr) else begin
        $display("[FAIL] m_req.addr: expected 0x%05h or 0x%05h, got 0x%05h",
                 qsfp_led_reg_addr, panel_led_reg_addr, got.addr);
        errors++;
      end
      exp = expected_write(got.addr, (got.addr == qsfp_led_reg_addr) ?
                           {16'h0, qsfp_val} : {24'h0, panel_val});
      assert (got.data == exp.data) else begin
        $display("[FAIL] m_req.data: expected 0x%08h, got 0x%08h", exp.data, got.data);
        errors++;
      end
      assert (got.byte_en == exp.byte_en) else begin
        $display("[FAIL] m_req.byte_en: expected 0x%0h, got 0x%0h", exp.byte_en, got.byte_en);
        errors++;
      end
      seen_addr.push_back(got.addr);
      seen_time.push_back(got.t);
      writes_checked++;
    end
  end

  // ----------------------------
  // Test helpers
  // ----------------------------

  task automatic start_test();
    seen_addr.delete();
    seen_time.delete();
    ack_time.delete();
    test_err_start = errors;
  endtask

  task automatic finish_test(input int num, input string name);
    $display("test %0d %s: %0d error(s)", num, name, errors - test_err_start);
    tests_run++;
  endtask

  task automatic drive_leds(input logic [15:0] q, input logic [7:0] p);
    @(negedge ctrlport_clk);
    qsfp_val   = q;
    panel_val  = p;
    qsfp_leds  = q;
    panel_leds = p;
  endtask

  // Ack count with a cycle limit, then a quiet window
  task automatic wait_for_acks(input int n);
    int limit;
    int cycles;
    limit  = n * (settle_cycles + max_ack + margin) * 2;
    cycles = 0;
    while (ack_time.size() < n && cycles < limit) begin
      @(negedge ctrlport_clk);
      cycles++;
    end
    assert (ack_time.size() >= n) else begin
      $display("Timed out waiting for %0d acks, saw %0d", n, ack_time.size());
      errors++;
    end
    repeat (quiet_cycles) @(negedge ctrlport_clk);
  endtask

  function automatic int count_addr(input logic [ctrlport_addr_w-1:0] addr);
    int n;
    n = 0;
    foreach (seen_addr[i]) begin
      if (seen_addr[i] == addr) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic expect_writes(input string name, input logic [ctrlport_addr_w-1:0] addr,
                               input int exp_n);
    int n;
    n = count_addr(addr);
    assert (n == exp_n) else begin
      $display("Expected %0d %s write(s), saw %0d", exp_n, name, n);
      errors++;
    end
  endtask

  // ----------------------------
  // Test sequence
  // ----------------------------

  initial begin
    void'($urandom(32'hc6c1_2cec));
    ctrlport_rst = 1'b1;
    m_resp       = '0;
    qsfp_val     = 16'($urandom);
    panel_val    = 8'($urandom);
    qsfp_leds    = qsfp_val;
    panel_leds   = panel_val;
    repeat (8) @(negedge ctrlport_clk);
    ctrlport_rst = 1'b0;

    // Both registers written once after reset with QSFP first
    start_test();
    wait_for_acks(2);
    expect_writes("QSFP", qsfp_led_reg_addr, 1);
    expect_writes("panel", panel_led_reg_addr, 1);
    assert (seen_addr.size() == 2 && seen_addr[0] == qsfp_led_reg_addr) else begin
      $display("Reset writes not in QSFP then panel order");
      errors++;
    end
    finish_test(1, "reset writes");

    start_test();
    drive_leds(qsfp_val ^ (16'($urandom) | 16'h0001), panel_val);
    wait_for_acks(1);
    expect_writes("QSFP", qsfp_led_reg_addr, 1);
    expect_writes("panel", panel_led_reg_addr, 0);
    finish_test(2, "QSFP change");

    // Slave error forces one retry after the settle delay
    start_test();
    inject_errs = 1;
    drive_leds(qsfp_val ^ (16'($urandom) | 16'h0001), panel_val);
    wait_for_acks(2);
    expect_writes("QSFP", qsfp_led_reg_addr, 2);
    expect_writes("panel", panel_led_reg_addr, 0);
    if (seen_time.size() >= 2 && ack_time.size() >= 1) begin
      assert (seen_time[1] - ack_time[0] >= min_gap) else begin
        $display("Retry came %0t after the error ack, too early", seen_time[1] - ack_time[0]);
        errors++;
      end
    end
    finish_test(3, "error retry");

    start_test();
    drive_leds(qsfp_val ^ (16'($urandom) | 16'h0001), panel_val ^ (8'($urandom) | 8'h01));
    wait_for_acks(2);
    expect_writes("QSFP", qsfp_led_reg_addr, 1);
    expect_writes("panel", panel_led_reg_addr, 1);
    finish_test(4, "both change");

    // Bus stays quiet while the inputs hold
    start_test();
    repeat (long_window) @(negedge ctrlport_clk);
    expect_writes("QSFP", qsfp_led_reg_addr, 0);
    expect_writes("panel", panel_led_reg_addr, 0);
    finish_test(5, "steady inputs");

    $display("%0d tests, %0d writes checked, %0d errors", tests_run, writes_checked, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdog_cycles * clk_period);
    $display("Run stopped by the watchdog after %0d cycles", watchdog_cycles);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
source/ctrlport_pkg.sv
source/led_pkg.sv
source/synchronizer.sv
source/led_status_forwarder.sv
source/ctrlport_combiner.sv
source/led_link_top.sv
bench/led_link_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the LED link simulation with Verilator

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
sim_bin=led_link_sim

verilator --binary --timing --assert -Wno-fatal \
  --top-module led_link_tb \
  -f files.f \
  -Mdir "$build_dir" \
  -o "$sim_bin"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Verification passed$" "$log_file"; then
  exit 0
fi
exit 1
